// File: rtl/xisog_pkg.sv
package xisog_pkg;

    // toy CSIDH prime, field elements are kept fully reduced
    localparam int FIELD_BITS = 10;
    localparam logic [FIELD_BITS-1:0] FIELD_PRIME = FIELD_BITS'(419);

    typedef logic [FIELD_BITS-1:0] fe_t;

    // odd isogeny degrees 3 to 15
    localparam int DEGREE_BITS = 4;

    typedef enum logic [1:0] {
        FP_MUL = 2'b00,
        FP_ADD = 2'b01,
        FP_SUB = 2'b10
    } fp_op_t;

    // one double-and-add step per bit of the second operand
    localparam int MUL_CYCLES = FIELD_BITS;

endpackage

// File: rtl/fp_alu.sv
`timescale 1ns/1ps

module fp_alu (
    input  logic              clk,
    input  logic              rst,
    input  logic              fp_req,
    input  xisog_pkg::fp_op_t fp_op,
    input  xisog_pkg::fe_t    fp_a,
    input  xisog_pkg::fe_t    fp_b,
    output logic              fp_done,
    output xisog_pkg::fe_t    fp_result
);

    logic                                     mul_run;
    logic [$clog2(xisog_pkg::MUL_CYCLES)-1:0] mul_cnt;
    xisog_pkg::fe_t                           mul_a;
    xisog_pkg::fe_t                           mul_b;
    xisog_pkg::fe_t                           dbl;
    xisog_pkg::fe_t                           mul_next;

    function automatic xisog_pkg::fe_t mod_add(xisog_pkg::fe_t a, xisog_pkg::fe_t b);
        logic [xisog_pkg::FIELD_BITS:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, xisog_pkg::FIELD_PRIME}) begin
            s = s - {1'b0, xisog_pkg::FIELD_PRIME};
        end
        return s[xisog_pkg::FIELD_BITS-1:0];
    endfunction

    function automatic xisog_pkg::fe_t mod_sub(xisog_pkg::fe_t a, xisog_pkg::fe_t b);
        xisog_pkg::fe_t d;
        // wraps modulo 2^FIELD_BITS, adding p brings it back in range
        d = a - b;
        if (a < b) begin
            d = d + xisog_pkg::FIELD_PRIME;
        end
        return d;
    endfunction

    // msb-first double and add, fp_result serves as the accumulator
    assign dbl      = mod_add(fp_result, fp_result);
    assign mul_next = mul_b[xisog_pkg::FIELD_BITS-1] ? mod_add(dbl, mul_a) : dbl;

    always_ff @(posedge clk) begin
        if (rst) begin
            mul_run <= 1'b0;
            fp_done <= 1'b0;
        end else begin
            fp_done <= 1'b0;
            if (mul_run) begin
                if (int'(mul_cnt) == xisog_pkg::MUL_CYCLES - 1) begin
                    mul_run <= 1'b0;
                    fp_done <= 1'b1;
                end
            end else if (fp_req) begin
                mul_run <= (fp_op == xisog_pkg::FP_MUL);
                fp_done <= (fp_op != xisog_pkg::FP_MUL);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_run) begin
            fp_result <= mul_next;
            mul_b     <= mul_b << 1;
            mul_cnt   <= mul_cnt + 1'b1;
        end else if (fp_req) begin
            mul_a   <= fp_a;
            mul_b   <= fp_b;
            mul_cnt <= '0;
            case (fp_op)
                xisog_pkg::FP_ADD: fp_result <= mod_add(fp_a, fp_b);
                xisog_pkg::FP_SUB: fp_result <= mod_sub(fp_a, fp_b);
                default:           fp_result <= '0;
            endcase
        end
    end

    a_no_req_in_mul: assert property (@(posedge clk) disable iff (rst) mul_run |-> !fp_req)
        else $error("field request while a multiply runs");

    a_reduced: assert property (@(posedge clk) disable iff (rst)
        fp_done |-> fp_result < xisog_pkg::FIELD_PRIME)
        else $error("field result not reduced");

endmodule

// File: rtl/xdbladd_seq.sv
`timescale 1ns/1ps

module xdbladd_seq (
    input  logic              clk,
    input  logic              rst,
    input  logic              pt_req,
    input  logic              pt_add,
    input  xisog_pkg::fe_t    px, pz, qx, qz, dx, dz,
    input  xisog_pkg::fe_t    a24_num, a24_den,
    output logic              pt_done,
    output xisog_pkg::fe_t    rx, rz,
    output logic              fp_req,
    output xisog_pkg::fp_op_t fp_op,
    output xisog_pkg::fe_t    fp_a, fp_b,
    input  logic              fp_done,
    input  xisog_pkg::fe_t    fp_result
);

    typedef enum logic [3:0] {
        S_PX, S_PZ, S_QX, S_QZ, S_DX, S_DZ, S_AN, S_AD, S_T0, S_T1, S_T2, S_T3
    } src_t;

    typedef enum logic [2:0] {D_T0, D_T1, D_T2, D_T3, D_RX, D_RZ} dst_t;

    typedef struct packed {
        xisog_pkg::fp_op_t op;
        src_t              a;
        src_t              b;
        dst_t              d;
    } cmd_t;

    logic           running;
    logic           issue;
    logic           add_mode;
    logic [3:0]     step;
    cmd_t           cmd;
    xisog_pkg::fe_t tmp [4];
    xisog_pkg::fe_t src [12];

    assign src = '{px, pz, qx, qz, dx, dz, a24_num, a24_den, tmp[0], tmp[1], tmp[2], tmp[3]};

    always_comb begin
        if (add_mode) begin
            // u = (xP-zP)(xQ+zQ), v = (xP+zP)(xQ-zQ)
            case (step)
                4'd0:    cmd = '{xisog_pkg::FP_SUB, S_PX, S_PZ, D_T0};
                4'd1:    cmd = '{xisog_pkg::FP_ADD, S_QX, S_QZ, D_T1};
                4'd2:    cmd = '{xisog_pkg::FP_MUL, S_T0, S_T1, D_T0};
                4'd3:    cmd = '{xisog_pkg::FP_ADD, S_PX, S_PZ, D_T1};
                4'd4:    cmd = '{xisog_pkg::FP_SUB, S_QX, S_QZ, D_T2};
                4'd5:    cmd = '{xisog_pkg::FP_MUL, S_T1, S_T2, D_T1};
                4'd6:    cmd = '{xisog_pkg::FP_ADD, S_T0, S_T1, D_T2};
                4'd7:    cmd = '{xisog_pkg::FP_SUB, S_T0, S_T1, D_T3};
                4'd8:    cmd = '{xisog_pkg::FP_MUL, S_T2, S_T2, D_T2};
                4'd9:    cmd = '{xisog_pkg::FP_MUL, S_T3, S_T3, D_T3};
                4'd10:   cmd = '{xisog_pkg::FP_MUL, S_DZ, S_T2, D_RX};
                default: cmd = '{xisog_pkg::FP_MUL, S_DX, S_T3, D_RZ};
            endcase
        end else begin
            // s = (x+z)^2 in t0, d = (x-z)^2 in t1
            case (step)
                4'd0:    cmd = '{xisog_pkg::FP_ADD, S_PX, S_PZ, D_T0};
                4'd1:    cmd = '{xisog_pkg::FP_SUB, S_PX, S_PZ, D_T1};
                4'd2:    cmd = '{xisog_pkg::FP_MUL, S_T0, S_T0, D_T0};
                4'd3:    cmd = '{xisog_pkg::FP_MUL, S_T1, S_T1, D_T1};
                4'd4:    cmd = '{xisog_pkg::FP_SUB, S_T0, S_T1, D_T2};
                4'd5:    cmd = '{xisog_pkg::FP_MUL, S_T0, S_T1, D_T3};
                4'd6:    cmd = '{xisog_pkg::FP_MUL, S_AD, S_T1, D_T0};
                4'd7:    cmd = '{xisog_pkg::FP_MUL, S_AN, S_T2, D_T1};
                4'd8:    cmd = '{xisog_pkg::FP_ADD, S_T0, S_T1, D_T0};
                4'd9:    cmd = '{xisog_pkg::FP_MUL, S_T2, S_T0, D_RZ};
                default: cmd = '{xisog_pkg::FP_MUL, S_AD, S_T3, D_RX};
            endcase
        end
    end

    assign fp_req = issue;
    assign fp_op  = cmd.op;
    assign fp_a   = src[cmd.a];
    assign fp_b   = src[cmd.b];

    always_ff @(posedge clk) begin
        if (rst) begin
            running  <= 1'b0;
            issue    <= 1'b0;
            add_mode <= 1'b0;
            step     <= '0;
            pt_done  <= 1'b0;
        end else begin
            issue   <= 1'b0;
            pt_done <= 1'b0;
            if (!running) begin
                if (pt_req) begin
                    running  <= 1'b1;
                    add_mode <= pt_add;
                    step     <= '0;
                    issue    <= 1'b1;
                end
            end else if (fp_done) begin
                if (step == (add_mode ? 4'd11 : 4'd10)) begin
                    running <= 1'b0;
                    pt_done <= 1'b1;
                end else begin
                    step  <= step + 1'b1;
                    issue <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (running && fp_done) begin
            case (cmd.d)
                D_RX:    rx <= fp_result;
                D_RZ:    rz <= fp_result;
                default: tmp[cmd.d[1:0]] <= fp_result;
            endcase
        end
    end

    a_no_req_while_running: assert property (@(posedge clk) disable iff (rst)
        running |-> !pt_req)
        else $error("point request while a sequence runs");

endmodule

// File: rtl/kernel_mult_store.sv
`timescale 1ns/1ps

module kernel_mult_store (
    input  logic           clk,
    input  logic           rst,
    input  logic           load_k,
    input  logic           advance,
    input  xisog_pkg::fe_t kx, kz,
    input  xisog_pkg::fe_t wr_x, wr_z,
    output xisog_pkg::fe_t cur_x, cur_z,
    output xisog_pkg::fe_t prev_x, prev_z
);

    xisog_pkg::fe_t m_x [3];
    xisog_pkg::fe_t m_z [3];
    // slot of the current multiple, i mod 3
    logic [1:0]     idx;
    logic [1:0]     nxt_idx;
    logic [1:0]     prv_idx;

    assign nxt_idx = (idx == 2'd2) ? 2'd0 : idx + 2'd1;
    assign prv_idx = (idx == 2'd0) ? 2'd2 : idx - 2'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            idx <= 2'd1;
        end else if (load_k) begin
            idx <= 2'd1;
        end else if (advance) begin
            idx <= nxt_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (load_k) begin
            m_x[1] <= kx;
            m_z[1] <= kz;
        end else if (advance) begin
            m_x[nxt_idx] <= wr_x;
            m_z[nxt_idx] <= wr_z;
        end
    end

    assign cur_x  = m_x[idx];
    assign cur_z  = m_z[idx];
    assign prev_x = m_x[prv_idx];
    assign prev_z = m_z[prv_idx];

    a_idx_mod3: assert property (@(posedge clk) disable iff (rst) idx != 2'd3)
        else $error("slot counter left the mod-3 range");

endmodule

// File: rtl/isog_ctrl.sv
`timescale 1ns/1ps

module isog_ctrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start,
    input  logic [xisog_pkg::DEGREE_BITS-1:0] l,
    input  xisog_pkg::fe_t                    px, pz, kx, kz,
    output logic                              busy,
    output logic                              done,
    output xisog_pkg::fe_t                    px_new, pz_new,
    output logic                              pt_req,
    output logic                              pt_add,
    output xisog_pkg::fe_t                    pt_px, pt_pz, pt_qx, pt_qz, pt_dx, pt_dz,
    input  logic                              pt_done,
    input  xisog_pkg::fe_t                    rx, rz,
    input  logic                              sq_req,
    input  xisog_pkg::fp_op_t                 sq_op,
    input  xisog_pkg::fe_t                    sq_a, sq_b,
    output logic                              sq_done,
    output logic                              fp_req,
    output xisog_pkg::fp_op_t                 fp_op,
    output xisog_pkg::fe_t                    fp_a, fp_b,
    input  logic                              fp_done,
    input  xisog_pkg::fe_t                    fp_result,
    output logic                              load_k,
    output logic                              advance,
    input  xisog_pkg::fe_t                    cur_x, cur_z, prev_x, prev_z
);

    typedef enum logic [1:0] {ST_IDLE, ST_OP, ST_PT} state_t;

    typedef enum logic [3:0] {
        C_PX, C_PZ, C_MX, C_MZ, C_QX, C_QZ, C_T0, C_T1, C_T2, C_T3
    } src_t;

    typedef enum logic [2:0] {D_T0, D_T1, D_T2, D_T3, D_QX, D_QZ, D_PXN, D_PZN} dst_t;

    typedef struct packed {
        xisog_pkg::fp_op_t op;
        src_t              a;
        src_t              b;
        dst_t              d;
    } cmd_t;

    state_t                            state;
    logic                              issue;
    logic [3:0]                        step;
    logic [xisog_pkg::DEGREE_BITS-1:0] l_r;
    logic [xisog_pkg::DEGREE_BITS-1:0] i;
    logic                              last_mult;
    xisog_pkg::fe_t                    px_r, pz_r, kx_r, kz_r;
    xisog_pkg::fe_t                    qx, qz;
    xisog_pkg::fe_t                    tmp [4];
    xisog_pkg::fe_t                    src [10];
    cmd_t                              cmd;

    assign busy      = (state != ST_IDLE);
    assign load_k    = start && !busy;
    assign last_mult = (i == (l_r >> 1));

    // M[1] is doubled, later multiples come from M[i] + K with difference M[i-1]
    assign pt_add  = (i != (xisog_pkg::DEGREE_BITS)'(1));
    assign pt_px   = cur_x;
    assign pt_pz   = cur_z;
    assign pt_qx   = kx_r;
    assign pt_qz   = kz_r;
    assign pt_dx   = prev_x;
    assign pt_dz   = prev_z;
    assign advance = (state == ST_PT) && pt_done;

    assign src = '{px_r, pz_r, cur_x, cur_z, qx, qz, tmp[0], tmp[1], tmp[2], tmp[3]};

    // steps 0-9 consume M[i], steps 10-13 form the image point
    always_comb begin
        case (step)
            4'd0:    cmd = '{xisog_pkg::FP_SUB, C_PX, C_PZ, D_T0};
            4'd1:    cmd = '{xisog_pkg::FP_ADD, C_MX, C_MZ, D_T1};
            4'd2:    cmd = '{xisog_pkg::FP_MUL, C_T0, C_T1, D_T0};
            4'd3:    cmd = '{xisog_pkg::FP_ADD, C_PX, C_PZ, D_T1};
            4'd4:    cmd = '{xisog_pkg::FP_SUB, C_MX, C_MZ, D_T2};
            4'd5:    cmd = '{xisog_pkg::FP_MUL, C_T1, C_T2, D_T1};
            4'd6:    cmd = '{xisog_pkg::FP_ADD, C_T0, C_T1, D_T2};
            4'd7:    cmd = '{xisog_pkg::FP_SUB, C_T0, C_T1, D_T3};
            4'd8:    cmd = '{xisog_pkg::FP_MUL, C_QX, C_T2, D_QX};
            4'd9:    cmd = '{xisog_pkg::FP_MUL, C_QZ, C_T3, D_QZ};
            4'd10:   cmd = '{xisog_pkg::FP_MUL, C_QX, C_QX, D_QX};
            4'd11:   cmd = '{xisog_pkg::FP_MUL, C_QZ, C_QZ, D_QZ};
            4'd12:   cmd = '{xisog_pkg::FP_MUL, C_PX, C_QX, D_PXN};
            default: cmd = '{xisog_pkg::FP_MUL, C_PZ, C_QZ, D_PZN};
        endcase
    end

    // the point unit owns the field unit while a point operation runs
    always_comb begin
        if (state == ST_PT) begin
            fp_req = sq_req;
            fp_op  = sq_op;
            fp_a   = sq_a;
            fp_b   = sq_b;
        end else begin
            fp_req = issue;
            fp_op  = cmd.op;
            fp_a   = src[cmd.a];
            fp_b   = src[cmd.b];
        end
    end

    assign sq_done = (state == ST_PT) && fp_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            issue  <= 1'b0;
            pt_req <= 1'b0;
            done   <= 1'b0;
            step   <= '0;
            i      <= '0;
        end else begin
            issue  <= 1'b0;
            pt_req <= 1'b0;
            done   <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_OP;
                        step  <= '0;
                        i     <= (xisog_pkg::DEGREE_BITS)'(1);
                        issue <= 1'b1;
                    end
                end
                ST_OP: begin
                    if (fp_done) begin
                        if (step == 4'd9 && !last_mult) begin
                            state  <= ST_PT;
                            pt_req <= 1'b1;
                        end else if (step == 4'd13) begin
                            state <= ST_IDLE;
                            done  <= 1'b1;
                        end else begin
                            step  <= step + 1'b1;
                            issue <= 1'b1;
                        end
                    end
                end
                ST_PT: begin
                    if (pt_done) begin
                        state <= ST_OP;
                        step  <= '0;
                        i     <= i + 1'b1;
                        issue <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_k) begin
            l_r  <= l;
            px_r <= px;
            pz_r <= pz;
            kx_r <= kx;
            kz_r <= kz;
            qx   <= xisog_pkg::fe_t'(1);
            qz   <= xisog_pkg::fe_t'(1);
        end else if (state == ST_OP && fp_done) begin
            case (cmd.d)
                D_QX:    qx <= fp_result;
                D_QZ:    qz <= fp_result;
                D_PXN:   px_new <= fp_result;
                D_PZN:   pz_new <= fp_result;
                default: tmp[cmd.d[1:0]] <= fp_result;
            endcase
        end
    end

    a_odd_degree: assert property (@(posedge clk) disable iff (rst)
        (start && !busy) |-> (l[0] && l >= 3))
        else $error("degree must be odd and at least 3");

    // a new multiple from the point unit becomes the current slot of the store
    a_store_rotates: assert property (@(posedge clk) disable iff (rst)
        advance |=> (cur_x == $past(rx) && cur_z == $past(rz)))
        else $error("new multiple not visible in the store");

endmodule

// File: rtl/xisog_top.sv
`timescale 1ns/1ps

module xisog_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start,
    input  logic [xisog_pkg::DEGREE_BITS-1:0] l,
    input  xisog_pkg::fe_t                    px, pz, kx, kz,
    input  xisog_pkg::fe_t                    a24_num, a24_den,
    output logic                              busy,
    output logic                              done,
    output xisog_pkg::fe_t                    px_new, pz_new
);

    logic              pt_req, pt_add, pt_done;
    xisog_pkg::fe_t    pt_px, pt_pz, pt_qx, pt_qz, pt_dx, pt_dz;
    xisog_pkg::fe_t    rx, rz;
    logic              sq_req, sq_done;
    xisog_pkg::fp_op_t sq_op;
    xisog_pkg::fe_t    sq_a, sq_b;
    logic              fp_req, fp_done;
    xisog_pkg::fp_op_t fp_op;
    xisog_pkg::fe_t    fp_a, fp_b, fp_result;
    logic              load_k, advance;
    xisog_pkg::fe_t    cur_x, cur_z, prev_x, prev_z;

    isog_ctrl i_ctrl (
        .clk(clk), .rst(rst), .start(start), .l(l),
        .px(px), .pz(pz), .kx(kx), .kz(kz),
        .busy(busy), .done(done), .px_new(px_new), .pz_new(pz_new),
        .pt_req(pt_req), .pt_add(pt_add),
        .pt_px(pt_px), .pt_pz(pt_pz), .pt_qx(pt_qx), .pt_qz(pt_qz),
        .pt_dx(pt_dx), .pt_dz(pt_dz), .pt_done(pt_done), .rx(rx), .rz(rz),
        .sq_req(sq_req), .sq_op(sq_op), .sq_a(sq_a), .sq_b(sq_b), .sq_done(sq_done),
        .fp_req(fp_req), .fp_op(fp_op), .fp_a(fp_a), .fp_b(fp_b),
        .fp_done(fp_done), .fp_result(fp_result),
        .load_k(load_k), .advance(advance),
        .cur_x(cur_x), .cur_z(cur_z), .prev_x(prev_x), .prev_z(prev_z)
    );

    xdbladd_seq i_point (
        .clk(clk), .rst(rst), .pt_req(pt_req), .pt_add(pt_add),
        .px(pt_px), .pz(pt_pz), .qx(pt_qx), .qz(pt_qz), .dx(pt_dx), .dz(pt_dz),
        .a24_num(a24_num), .a24_den(a24_den),
        .pt_done(pt_done), .rx(rx), .rz(rz),
        .fp_req(sq_req), .fp_op(sq_op), .fp_a(sq_a), .fp_b(sq_b),
        .fp_done(sq_done), .fp_result(fp_result)
    );

    kernel_mult_store i_store (
        .clk(clk), .rst(rst), .load_k(load_k), .advance(advance),
        .kx(kx), .kz(kz), .wr_x(rx), .wr_z(rz),
        .cur_x(cur_x), .cur_z(cur_z), .prev_x(prev_x), .prev_z(prev_z)
    );

    fp_alu i_alu (
        .clk(clk), .rst(rst), .fp_req(fp_req), .fp_op(fp_op),
        .fp_a(fp_a), .fp_b(fp_b), .fp_done(fp_done), .fp_result(fp_result)
    );

endmodule

// File: dv/tb_xisog.sv
`timescale 1ns/1ps

module tb_xisog;

    localparam int CLK_PERIOD   = 8;
    localparam int MAX_CASES    = 16;
    localparam int IDLE_TIMEOUT = 100;
    localparam int DONE_TIMEOUT = 5000;
    localparam int PRIME        = int'(xisog_pkg::FIELD_PRIME);

    logic                              clk = 1'b0;
    logic                              rst;
    logic                              start;
    logic [xisog_pkg::DEGREE_BITS-1:0] l;
    xisog_pkg::fe_t                    px, pz, kx, kz, a24_num, a24_den;
    logic                              busy;
    logic                              done;
    xisog_pkg::fe_t                    px_new, pz_new;

    // one row per case with l px pz kx kz a24_num a24_den x_expected z_expected
    int cases [MAX_CASES][9];
    int num_cases;
    int value_errors;
    int protocol_errors;
    int results_checked;
    bit aborted;

    xisog_top i_dut (
        .clk(clk), .rst(rst), .start(start), .l(l),
        .px(px), .pz(pz), .kx(kx), .kz(kz), .a24_num(a24_num), .a24_den(a24_den),
        .busy(busy), .done(done), .px_new(px_new), .pz_new(pz_new)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int mul_mod(input int a, input int b);
        return (a * b) % PRIME;
    endfunction

    function automatic int field_inverse(input int a);
        int inv;
        inv = 0;
        for (int b = 1; b < PRIME; b++) begin
            if (mul_mod(a, b) == 1) begin
                inv = b;
            end
        end
        return inv;
    endfunction

    function automatic int random_scalar();
        return int'($urandom_range(PRIME - 1, 1));
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic expect_flag(input string name, input logic got, input logic want);
        assert (got === want) else begin
            $display("[FAIL] %0t ns: %s = %b, expected %b", $time, name, got, want);
            protocol_errors++;
        end
    endtask

    task automatic compare_value(input string name, input int got, input int want);
        assert (got == want) else begin
            $display("[FAIL] %0t ns: %s = %0d, expected %0d", $time, name, got, want);
            value_errors++;
        end
    endtask

    task automatic load_cases();
        int    fd;
        int    n;
        int    f [9];
        string line;
        fd = $fopen("dv/xisog_cases.txt", "r");
        assert (fd != 0) else begin
            $display("could not open the cases file dv/xisog_cases.txt");
            protocol_errors++;
        end
        if (fd == 0) begin
            aborted = 1'b1;
            return;
        end
        while (!$feof(fd) && num_cases < MAX_CASES) begin
            line = "";
            void'($fgets(line, fd));
            // header lines start with # and do not scan as a case
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
            if (n == 9) begin
                cases[num_cases] = f;
                num_cases++;
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_operands(input int idx, input int lam, input int mu);
        l  = (xisog_pkg::DEGREE_BITS)'(cases[idx][0]);
        px = xisog_pkg::fe_t'(mul_mod(cases[idx][1], lam));
        pz = xisog_pkg::fe_t'(mul_mod(cases[idx][2], lam));
        kx = xisog_pkg::fe_t'(mul_mod(cases[idx][3], mu));
        kz = xisog_pkg::fe_t'(mul_mod(cases[idx][4], mu));
    endtask

    task automatic apply_case(input int idx, input int lam, input int mu);
        drive_operands(idx, lam, mu);
        a24_num = xisog_pkg::fe_t'(cases[idx][5]);
        a24_den = xisog_pkg::fe_t'(cases[idx][6]);
    endtask

    task automatic wait_idle(output bit ok);
        int cycles;
        cycles = 0;
        while (busy && cycles < IDLE_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        ok = !busy;
        assert (ok) else begin
            $display("timeout: busy stayed high for %0d cycles before a start", IDLE_TIMEOUT);
            protocol_errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic await_done(output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < DONE_TIMEOUT) begin
            next_cycle();
            cycles++;
            ok = (done === 1'b1);
        end
        assert (ok) else begin
            $display("timeout: done did not rise within %0d cycles", DONE_TIMEOUT);
            protocol_errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic verify_image(input int idx);
        int exp_x;
        int exp_z;
        exp_x = cases[idx][7];
        exp_z = cases[idx][8];
        results_checked++;
        if (exp_z == 0) begin
            compare_value("pz_new", int'(pz_new), 0);
        end else begin
            assert (pz_new != '0) else begin
                $display("[FAIL] %0t ns: pz_new = 0, expected a nonzero value", $time);
                value_errors++;
            end
            // projective match means px_new * exp_z == exp_x * pz_new
            compare_value("px_new", int'(px_new),
                          mul_mod(mul_mod(exp_x, int'(pz_new)), field_inverse(exp_z)));
        end
    endtask

    task automatic launch(input int idx, input int lam, input int mu, output bit ok);
        wait_idle(ok);
        if (!ok) return;
        apply_case(idx, lam, mu);
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        expect_flag("busy", busy, 1'b1);
    endtask

    task automatic complete_run(input int idx, output bit ok);
        await_done(ok);
        if (!ok) return;
        verify_image(idx);
        next_cycle();
        // done is a single-cycle pulse
        expect_flag("done", done, 1'b0);
    endtask

    task automatic run_case(input int idx, input int lam, input int mu);
        bit ok;
        if (aborted) return;
        launch(idx, lam, mu, ok);
        if (ok) begin
            complete_run(idx, ok);
        end
    endtask

    task automatic ignored_start(input int idx, input int other);
        bit             ok;
        xisog_pkg::fe_t held_x;
        xisog_pkg::fe_t held_z;
        if (aborted) return;
        launch(idx, 1, 1, ok);
        if (!ok) return;
        repeat (5) next_cycle();
        // second start with other operands while busy and a24 left as it is
        drive_operands(other, 1, 1);
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        expect_flag("busy", busy, 1'b1);
        complete_run(idx, ok);
        if (!ok) return;
        held_x = px_new;
        held_z = pz_new;
        repeat (5) begin
            next_cycle();
            expect_flag("busy", busy, 1'b0);
            expect_flag("done", done, 1'b0);
            compare_value("px_new", int'(px_new), int'(held_x));
            compare_value("pz_new", int'(pz_new), int'(held_z));
        end
    endtask

    task automatic reset_during_run(input int idx);
        bit ok;
        if (aborted) return;
        launch(idx, 1, 1, ok);
        if (!ok) return;
        repeat (40) next_cycle();
        expect_flag("busy", busy, 1'b1);
        rst = 1'b1;
        repeat (3) begin
            next_cycle();
            expect_flag("busy", busy, 1'b0);
            expect_flag("done", done, 1'b0);
        end
        rst = 1'b0;
        next_cycle();
        expect_flag("busy", busy, 1'b0);
        expect_flag("done", done, 1'b0);
    endtask

    initial begin
        void'($urandom(32'h2303d1d0));
        rst     = 1'b1;
        start   = 1'b0;
        l       = '0;
        px      = '0;
        pz      = '0;
        kx      = '0;
        kz      = '0;
        a24_num = '0;
        a24_den = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        load_cases();
        assert (aborted || num_cases >= 8) else begin
            $display("the cases file holds %0d cases, at least 8 are needed", num_cases);
            protocol_errors++;
            aborted = 1'b1;
        end
        for (int c = 0; c < num_cases; c++) begin
            run_case(c, 1, 1);
        end
        // scaled P and K give the same image since the formulas are homogeneous
        for (int c = 0; c < num_cases; c++) begin
            run_case(c, random_scalar(), random_scalar());
        end
        ignored_start(4, 5);
        reset_during_run(4);
        run_case(7, 1, 1);
        $display("results checked: %0d, value errors: %0d, protocol errors: %0d",
                 results_checked, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: dv/xisog_cases.txt
# columns l px pz kx kz a24_num a24_den x_expected z_expected
# decimal field elements modulo 419 with the image point in projective form
3 5 1 2 1 3 1 405 9
5 5 1 2 1 3 1 107 343
7 5 1 2 1 3 1 276 25
9 5 1 2 1 3 1 60 45
11 5 1 2 1 3 1 300 337
3 7 3 3 2 5 2 318 75
5 7 3 3 2 5 2 41 81
7 7 3 3 2 5 2 411 208

// File: build.f
rtl/xisog_pkg.sv
rtl/fp_alu.sv
rtl/xdbladd_seq.sv
rtl/kernel_mult_store.sv
rtl/isog_ctrl.sv
rtl/xisog_top.sv
dv/tb_xisog.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the xisog testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module tb_xisog -o sim_xisog
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_xisog > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTS PASSED" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1
